// File: hdl/sys_bus_pkg.sv
package sys_bus_pkg;

	localparam int ADDR_W    = 32;	// bus address width
	localparam int DATA_W    = 32;	// bus data width
	localparam int PIX_W     = 8;	// one pixel per byte
	localparam int LEN_W     = 16;	// job length in words

	localparam int MEM_WORDS = 1024;	// ram depth
	localparam int MEM_AW    = 10;	// word index, addr bits 11..2

	localparam logic [ADDR_W-1:0] MEM_LIMIT = 32'h7FFF_FFFF;	// memory window top
	localparam logic [ADDR_W-1:0] PIX_BASE  = 32'h8000_0000;	// register window
	localparam logic [ADDR_W-1:0] PIX_LIMIT = 32'h8000_000F;

	// word index inside the register window, addr bits 3..2
	localparam logic [1:0] REG_SRC  = 2'd0;
	localparam logic [1:0] REG_DST  = 2'd1;
	localparam logic [1:0] REG_LEN  = 2'd2;
	localparam logic [1:0] REG_CTRL = 2'd3;

	localparam int CTRL_START  = 0;	// write side
	localparam int CTRL_BUSY   = 0;	// read side
	localparam int CTRL_DONE   = 1;	// read side, sticky
	localparam int CTRL_OFS_LO = 8;	// brightness offset, both sides
	localparam int CTRL_OFS_HI = 15;

	localparam logic [1:0] GNT_NONE = 2'b00;	// bus free
	localparam logic [1:0] GNT_CPU  = 2'b01;
	localparam logic [1:0] GNT_PIX  = 2'b10;

endpackage

// File: hdl/bus_ifs.sv
interface sys_bus_if;
	import sys_bus_pkg::*;

	logic              cs_n;	// chip select, low active
	logic              we;	// 1 write, 0 read
	logic [ADDR_W-1:0] addr;
	logic [DATA_W-1:0] wdata;
	logic [DATA_W-1:0] rdata;
	logic              ack;	// one cycle slave response

	modport master (output cs_n, we, addr, wdata, input rdata, ack);
	modport slave  (input cs_n, we, addr, wdata, output rdata, ack);

endinterface

interface pix_cmd_if;
	import sys_bus_pkg::*;

	logic              start;	// one cycle kick
	logic [ADDR_W-1:0] src;
	logic [ADDR_W-1:0] dst;
	logic [LEN_W-1:0]  len;	// words
	logic [PIX_W-1:0]  offset;	// added to every pixel
	logic              busy;	// level while a job runs
	logic              done;	// one cycle at job end

	modport regs (output start, src, dst, len, offset, input busy, done);
	modport dma  (input start, src, dst, len, offset, output busy, done);

endinterface

// File: hdl/bus_arbiter.sv
module bus_arbiter (
	input  logic       clk,
	input  logic       reset,
	input  logic [1:0] req,	// bit 0 cpu, bit 1 pixel dma
	output logic [1:0] gnt
);
	import sys_bus_pkg::*;

	logic [1:0] gnt_nxt;
	logic       last_pix;	// 1 when the pixel dma owned the bus last

	always_comb begin
		gnt_nxt = GNT_NONE;
		case (gnt)
			GNT_CPU: begin	// locked while cpu keeps requesting
				if (req[0])      gnt_nxt = GNT_CPU;
				else if (req[1]) gnt_nxt = GNT_PIX;
			end
			GNT_PIX: begin
				if (req[1])      gnt_nxt = GNT_PIX;
				else if (req[0]) gnt_nxt = GNT_CPU;
			end
			default: begin	// free bus
				if (req[0] && req[1])
					gnt_nxt = last_pix ? GNT_CPU : GNT_PIX;	// round robin
				else if (req[0])
					gnt_nxt = GNT_CPU;
				else if (req[1])
					gnt_nxt = GNT_PIX;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			gnt      <= GNT_NONE;
			last_pix <= 1'b0;
		end else begin
			gnt <= gnt_nxt;
			if (gnt_nxt != GNT_NONE)
				last_pix <= (gnt_nxt == GNT_PIX);	// remember the owner
		end
	end

endmodule

// File: hdl/bus_hub.sv
module bus_hub (
	input  logic       clk,
	input  logic       reset,
	sys_bus_if.slave   cpu,	// cpu as master
	sys_bus_if.slave   dma,	// pixel dma as master
	sys_bus_if.master  mem,	// word ram as slave
	sys_bus_if.master  regs,	// pixel registers as slave
	output logic [1:0] req,
	input  logic [1:0] gnt
);
	import sys_bus_pkg::*;

	logic              bus_cs_n;	// granted master's select
	logic              bus_we;
	logic [ADDR_W-1:0] bus_addr;
	logic [DATA_W-1:0] bus_wdata;
	logic [DATA_W-1:0] bus_rdata;
	logic              bus_ack;
	logic              sel_mem;
	logic              sel_reg;
	logic              err_ack;	// unmapped responder

	assign req = {~dma.cs_n, ~cpu.cs_n};

	// master side mux keeps cs_n high without a grant
	always_comb begin
		bus_cs_n  = 1'b1;
		bus_we    = cpu.we;
		bus_addr  = cpu.addr;
		bus_wdata = cpu.wdata;
		if (gnt == GNT_CPU) begin
			bus_cs_n = cpu.cs_n;
		end else if (gnt == GNT_PIX) begin
			bus_cs_n  = dma.cs_n;
			bus_we    = dma.we;
			bus_addr  = dma.addr;
			bus_wdata = dma.wdata;
		end
	end

	// address decode
	assign sel_mem = (bus_addr <= MEM_LIMIT);
	assign sel_reg = (bus_addr >= PIX_BASE) && (bus_addr <= PIX_LIMIT);

	assign mem.cs_n  = sel_mem ? bus_cs_n : 1'b1;
	assign mem.we    = bus_we;
	assign mem.addr  = bus_addr;
	assign mem.wdata = bus_wdata;

	assign regs.cs_n  = sel_reg ? bus_cs_n : 1'b1;
	assign regs.we    = bus_we;
	assign regs.addr  = bus_addr;
	assign regs.wdata = bus_wdata;

	// single one cycle ack for holes in the map
	always_ff @(posedge clk) begin
		if (reset)
			err_ack <= 1'b0;
		else
			err_ack <= ~bus_cs_n & ~sel_mem & ~sel_reg & ~err_ack;
	end

	// slave side return path
	assign bus_rdata = sel_mem ? mem.rdata :
	                   sel_reg ? regs.rdata : '0;	// unmapped reads 0
	assign bus_ack   = sel_mem ? mem.ack :
	                   sel_reg ? regs.ack : err_ack;

	assign cpu.rdata = bus_rdata;
	assign dma.rdata = bus_rdata;
	assign cpu.ack   = (gnt == GNT_CPU) & bus_ack;	// only owner sees ack
	assign dma.ack   = (gnt == GNT_PIX) & bus_ack;

endmodule

// File: hdl/sram_slave.sv
module sram_slave (
	input  logic     clk,
	input  logic     reset,
	sys_bus_if.slave bus
);
	import sys_bus_pkg::*;

	logic [DATA_W-1:0] mem [MEM_WORDS];	// word storage
	logic [MEM_AW-1:0] idx;
	logic              access;	// accepted this cycle

	assign idx    = bus.addr[MEM_AW+1:2];	// aliases every 4 KB
	assign access = ~bus.cs_n & ~bus.ack;	// no ack back to back

	always_ff @(posedge clk) begin
		if (reset)
			bus.ack <= 1'b0;
		else
			bus.ack <= access;
	end

	// data path, written or read on the edge raising ack
	always_ff @(posedge clk) begin
		if (access) begin
			if (bus.we)
				mem[idx] <= bus.wdata;
			else
				bus.rdata <= mem[idx];	// valid with ack
		end
	end

endmodule

// File: hdl/pix_regs.sv
module pix_regs (
	input  logic     clk,
	input  logic     reset,
	sys_bus_if.slave bus,
	pix_cmd_if.regs  cmd,
	output logic     pix_done	// sticky done level
);
	import sys_bus_pkg::*;

	logic [1:0]        reg_idx;
	logic              access;
	logic              done_flag;	// set by done pulse, cleared by start
	logic [DATA_W-1:0] ctrl_rd;

	assign reg_idx  = bus.addr[3:2];
	assign access   = ~bus.cs_n & ~bus.ack;	// one ack per transfer
	assign pix_done = done_flag;

	// status word
	always_comb begin
		ctrl_rd                          = '0;
		ctrl_rd[CTRL_BUSY]               = cmd.busy;
		ctrl_rd[CTRL_DONE]               = done_flag;
		ctrl_rd[CTRL_OFS_HI:CTRL_OFS_LO] = cmd.offset;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			bus.ack    <= 1'b0;
			cmd.start  <= 1'b0;
			cmd.src    <= '0;
			cmd.dst    <= '0;
			cmd.len    <= '0;
			cmd.offset <= '0;
			done_flag  <= 1'b0;
		end else begin
			bus.ack   <= access;
			cmd.start <= 1'b0;	// pulse only
			if (cmd.done)
				done_flag <= 1'b1;
			if (access && bus.we && !cmd.busy) begin	// locked during a job
				case (reg_idx)
					REG_SRC: cmd.src <= bus.wdata;
					REG_DST: cmd.dst <= bus.wdata;
					REG_LEN: cmd.len <= bus.wdata[LEN_W-1:0];
					REG_CTRL: begin
						cmd.offset <= bus.wdata[CTRL_OFS_HI:CTRL_OFS_LO];
						if (bus.wdata[CTRL_START]) begin
							cmd.start <= 1'b1;	// lands with the ack
							done_flag <= 1'b0;
						end
					end
					default: ;
				endcase
			end
		end
	end

	// read data, registered with the ack
	always_ff @(posedge clk) begin
		if (access && !bus.we) begin
			case (reg_idx)
				REG_SRC: bus.rdata <= cmd.src;
				REG_DST: bus.rdata <= cmd.dst;
				REG_LEN: bus.rdata <= {{(DATA_W-LEN_W){1'b0}}, cmd.len};
				default: bus.rdata <= ctrl_rd;
			endcase
		end
	end

endmodule

// File: hdl/pix_dma.sv
module pix_dma (
	input  logic      clk,
	input  logic      reset,
	sys_bus_if.master bus,
	pix_cmd_if.dma    cmd
);
	import sys_bus_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		READ,
		WRITE,
		GAP
	} state_t;

	state_t            state;
	logic              wr_next;	// what follows the gap
	logic [LEN_W-1:0]  count;	// words still to move
	logic [ADDR_W-1:0] src_ptr;
	logic [ADDR_W-1:0] dst_ptr;
	logic [DATA_W-1:0] pix_buf;	// brightened word waiting for write

	// per byte add with clamp at full scale
	function automatic logic [DATA_W-1:0] brighten(
		input logic [DATA_W-1:0] word,
		input logic [PIX_W-1:0]  ofs
	);
		logic [PIX_W:0]    sum;
		logic [DATA_W-1:0] res;
		res = '0;
		for (int i = 0; i < DATA_W / PIX_W; i++) begin
			sum = {1'b0, word[i*PIX_W +: PIX_W]} + {1'b0, ofs};
			res[i*PIX_W +: PIX_W] = sum[PIX_W] ? {PIX_W{1'b1}} : sum[PIX_W-1:0];
		end
		return res;
	endfunction

	// bus outputs straight from state, stable until ack
	assign bus.cs_n  = ~((state == READ) || (state == WRITE));
	assign bus.we    = (state == WRITE);
	assign bus.addr  = (state == WRITE) ? dst_ptr : src_ptr;
	assign bus.wdata = pix_buf;

	always_ff @(posedge clk) begin
		if (reset) begin
			state    <= IDLE;
			wr_next  <= 1'b0;
			count    <= '0;
			cmd.busy <= 1'b0;
			cmd.done <= 1'b0;
		end else begin
			cmd.done <= 1'b0;
			case (state)
				IDLE: if (cmd.start) begin
					if (cmd.len == '0) begin
						cmd.done <= 1'b1;	// empty job ends at once
					end else begin
						count    <= cmd.len;
						cmd.busy <= 1'b1;
						state    <= READ;
					end
				end
				READ: if (bus.ack) begin
					wr_next <= 1'b1;
					state   <= GAP;	// let the cpu in between words
				end
				WRITE: if (bus.ack) begin
					count <= count - 1'b1;
					if (count == 1) begin	// last word written
						cmd.busy <= 1'b0;
						cmd.done <= 1'b1;
						state    <= IDLE;
					end else begin
						wr_next <= 1'b0;
						state   <= GAP;
					end
				end
				default: state <= wr_next ? WRITE : READ;	// gap, cs_n high
			endcase
		end
	end

	// address and data path
	always_ff @(posedge clk) begin
		if (state == IDLE && cmd.start) begin
			src_ptr <= cmd.src;
			dst_ptr <= cmd.dst;
		end
		if (state == READ && bus.ack)
			pix_buf <= brighten(bus.rdata, cmd.offset);
		if (state == WRITE && bus.ack) begin
			src_ptr <= src_ptr + 4;	// next word
			dst_ptr <= dst_ptr + 4;
		end
	end

endmodule

// File: hdl/soc_top.sv
module soc_top (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            cpu_cs_n,	// low active select
	input  logic                            cpu_we,	// 1 write, 0 read
	input  logic [sys_bus_pkg::ADDR_W-1:0]  cpu_addr,
	input  logic [sys_bus_pkg::DATA_W-1:0]  cpu_wdata,
	output logic [sys_bus_pkg::DATA_W-1:0]  cpu_rdata,
	output logic                            cpu_ack,
	output logic                            pix_done	// job finished level
);

	logic [1:0] req;	// bit 0 cpu, bit 1 pixel dma
	logic [1:0] gnt;

	sys_bus_if cpu_bus ();	// cpu to hub
	sys_bus_if dma_bus ();	// pixel dma to hub
	sys_bus_if mem_bus ();	// hub to ram
	sys_bus_if reg_bus ();	// hub to pixel registers
	pix_cmd_if pix_cmd ();	// registers to dma

	// cpu pins onto the bus
	assign cpu_bus.cs_n  = cpu_cs_n;
	assign cpu_bus.we    = cpu_we;
	assign cpu_bus.addr  = cpu_addr;
	assign cpu_bus.wdata = cpu_wdata;
	assign cpu_rdata     = cpu_bus.rdata;
	assign cpu_ack       = cpu_bus.ack;

	bus_arbiter u_arbiter (
		.clk   (clk),
		.reset (reset),
		.req   (req),
		.gnt   (gnt)
	);

	bus_hub u_hub (
		.clk   (clk),
		.reset (reset),
		.cpu   (cpu_bus),
		.dma   (dma_bus),
		.mem   (mem_bus),
		.regs  (reg_bus),
		.req   (req),
		.gnt   (gnt)
	);

	sram_slave u_sram (
		.clk   (clk),
		.reset (reset),
		.bus   (mem_bus)
	);

	pix_regs u_pix_regs (
		.clk      (clk),
		.reset    (reset),
		.bus      (reg_bus),
		.cmd      (pix_cmd),
		.pix_done (pix_done)
	);

	pix_dma u_pix_dma (
		.clk   (clk),
		.reset (reset),
		.bus   (dma_bus),
		.cmd   (pix_cmd)
	);

endmodule

// File: sim/tb_soc.sv
module tb_soc;
	timeunit 1ns;
	timeprecision 1ps;
	import sys_bus_pkg::*;

	localparam int ACK_TIMEOUT  = 64;	// cycles allowed per bus access
	localparam int MAX_POLLS    = 300;	// status reads before giving up
	localparam int JOB_LEN      = 24;	// words in the brightness job
	localparam int BUS_ACCESSES = 600;	// upper bound over all tests
	localparam int WATCHDOG_NS  = 4 * (JOB_LEN * 16 + BUS_ACCESSES * 8 + 2000);
	localparam logic [31:0] SRC_ADDR  = 32'h0000_0100;
	localparam logic [31:0] DST_ADDR  = 32'h0000_0400;
	localparam logic [31:0] CTRL_ADDR = 32'h8000_000C;

	logic        clk;
	logic        reset;
	logic        cpu_cs_n;
	logic        cpu_we;
	logic [31:0] cpu_addr;
	logic [31:0] cpu_wdata;
	logic [31:0] cpu_rdata;
	logic        cpu_ack;
	logic        pix_done;

	int          errors;
	int          checks;
	int          last_lat;	// rising edges from cs_n fall to ack
	logic [31:0] ref_mem [int unsigned];	// expected ram words by word index

	soc_top u_dut (
		.clk       (clk),
		.reset     (reset),
		.cpu_cs_n  (cpu_cs_n),
		.cpu_we    (cpu_we),
		.cpu_addr  (cpu_addr),
		.cpu_wdata (cpu_wdata),
		.cpu_rdata (cpu_rdata),
		.cpu_ack   (cpu_ack),
		.pix_done  (pix_done)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;	// 4 ns period
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: run still busy after %0d ns", WATCHDOG_NS);
		$display("checks: %0d, errors: %0d", checks, errors);
		$display("*** FAILED ***");
		$finish;
	end

	function automatic void compare_word(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("[FAIL] %s: got %h, expected %h", name, got, exp);
		end
	endfunction

	function automatic void confirm(input bit ok, input string what);
		checks++;
		assert (ok) else begin
			errors++;
			$display("ERROR: %s", what);
		end
	endfunction

	function automatic int unsigned word_index(input logic [31:0] addr);
		return addr[11:2];	// ram repeats every 4 KB
	endfunction

	// each byte plus offset clipped to 255
	function automatic logic [31:0] saturate_add_pixels(input logic [31:0] word,
			input logic [7:0] ofs);
		logic [31:0] res;
		int          sum;
		res = '0;
		for (int b = 0; b < 4; b++) begin
			sum = int'(word[8*b +: 8]) + int'(ofs);
			res[8*b +: 8] = (sum > 255) ? 8'hFF : sum[7:0];
		end
		return res;
	endfunction

	// one cpu transfer holding cs_n until ack
	task automatic bus_access(input logic we, input logic [31:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata);
		int cycles;
		bit acked;
		cycles = 0;
		acked  = 1'b0;
		rdata  = '0;
		@(posedge clk);
		cpu_cs_n  <= 1'b0;
		cpu_we    <= we;
		cpu_addr  <= addr;
		cpu_wdata <= wdata;
		while (!acked && cycles < ACK_TIMEOUT) begin
			@(negedge clk);	// outputs settled here
			cycles++;
			if (cpu_ack) begin
				acked = 1'b1;
				rdata = cpu_rdata;
			end
		end
		confirm(acked, $sformatf("no ack for access to address %h", addr));
		last_lat = cycles - 1;
		@(posedge clk);	// ack seen on this edge
		cpu_cs_n <= 1'b1;
		cpu_we   <= 1'b0;
	endtask

	task automatic cpu_write(input logic [31:0] addr, input logic [31:0] data);
		logic [31:0] dummy_rd;
		bus_access(1'b1, addr, data, dummy_rd);
		if (addr <= MEM_LIMIT)
			ref_mem[word_index(addr)] = data;	// memory window only
	endtask

	task automatic cpu_read(input logic [31:0] addr, output logic [31:0] data);
		bus_access(1'b0, addr, '0, data);
	endtask

	task automatic verify_memory(input string tag);
		logic [31:0] rd;
		foreach (ref_mem[i]) begin
			cpu_read(i << 2, rd);
			compare_word($sformatf("cpu_rdata @%h %s", i << 2, tag), rd, ref_mem[i]);
		end
	endtask

	task automatic wait_for_done();
		logic [31:0] status;
		int          polls;
		polls  = 0;
		status = '0;
		while (status[1] !== 1'b1 && polls < MAX_POLLS) begin
			cpu_read(CTRL_ADDR, status);	// bit 1 done, bit 0 busy
			polls++;
		end
		confirm(status[1] === 1'b1, "pixel job never reported done");
		compare_word("status busy", {31'b0, status[0]}, 32'h0);
	endtask

	task automatic reset_and_first_write();
		@(negedge clk);
		compare_word("cpu_ack", {31'b0, cpu_ack}, 32'h0);
		compare_word("pix_done", {31'b0, pix_done}, 32'h0);
		cpu_write(32'h0000_0040, $urandom());
		compare_word("cpu_ack latency", last_lat, 32'd2);	// grant then slave
	endtask

	task automatic mem_round_trip();
		logic [31:0] addrs [32];
		logic [31:0] data;
		logic [31:0] rd;
		for (int i = 0; i < 32; i++) begin
			addrs[i] = $urandom_range(0, MEM_WORDS - 1) << 2;	// below 4 KB
			cpu_write(addrs[i], $urandom());
		end
		for (int i = 0; i < 32; i++) begin
			cpu_read(addrs[i], rd);
			compare_word($sformatf("cpu_rdata @%h", addrs[i]), rd,
				ref_mem[word_index(addrs[i])]);
		end
		data = $urandom();
		cpu_write(addrs[0] + 32'd4096, data);	// one window up
		cpu_read(addrs[0], rd);
		compare_word("cpu_rdata alias", rd, data);
	endtask

	task automatic reg_readback();
		logic [31:0] src;
		logic [31:0] dst;
		logic [31:0] len_wr;
		logic [31:0] rd;
		logic [7:0]  ofs;
		src    = $urandom();
		dst    = $urandom();
		len_wr = $urandom();
		ofs    = 8'($urandom());
		cpu_write(PIX_BASE, src);
		cpu_write(PIX_BASE + 4, dst);
		cpu_write(PIX_BASE + 8, len_wr);
		cpu_write(CTRL_ADDR, {16'h0, ofs, 8'h00});	// offset without start
		cpu_read(PIX_BASE, rd);
		compare_word("SRC", rd, src);
		cpu_read(PIX_BASE + 4, rd);
		compare_word("DST", rd, dst);
		cpu_read(PIX_BASE + 8, rd);
		compare_word("LEN", rd, {16'h0, len_wr[15:0]});	// 16 bit register
		cpu_read(CTRL_ADDR, rd);
		compare_word("CTRL offset", {24'h0, rd[15:8]}, {24'h0, ofs});
		compare_word("CTRL busy done", {30'h0, rd[1:0]}, 32'h0);
	endtask

	task automatic unmapped_access();
		logic [31:0] rd;
		// ram words the unmapped addresses would land on if decoded as memory
		cpu_write(32'h0000_0010, $urandom());
		cpu_write(32'h0000_0000, $urandom());
		cpu_read(32'h8000_0010, rd);	// just past the registers
		compare_word("cpu_rdata @80000010", rd, 32'h0);
		cpu_read(32'hFFFF_0000, rd);
		compare_word("cpu_rdata @ffff0000", rd, 32'h0);
		cpu_write(32'h8000_0010, $urandom());
		cpu_write(32'hFFFF_0000, $urandom());
		verify_memory("after unmapped writes");
	endtask

	task automatic brightness_job();
		logic [31:0] rd;
		logic [31:0] exp_word;
		logic [7:0]  ofs;
		ofs = 8'($urandom_range(32, 224));	// high enough to clip some pixels
		for (int k = 0; k < JOB_LEN; k++)
			cpu_write(SRC_ADDR + 4 * k, $urandom());
		cpu_write(DST_ADDR + 4 * JOB_LEN, $urandom());	// guard past the end
		cpu_write(PIX_BASE, SRC_ADDR);
		cpu_write(PIX_BASE + 4, DST_ADDR);
		cpu_write(PIX_BASE + 8, JOB_LEN);
		cpu_write(CTRL_ADDR, {16'h0, ofs, 8'h01});	// offset and start
		wait_for_done();
		@(negedge clk);
		compare_word("pix_done", {31'b0, pix_done}, 32'h1);
		for (int k = 0; k < JOB_LEN; k++) begin
			exp_word = saturate_add_pixels(ref_mem[word_index(SRC_ADDR + 4 * k)], ofs);
			cpu_read(DST_ADDR + 4 * k, rd);
			compare_word($sformatf("cpu_rdata dst word %0d", k), rd, exp_word);
			ref_mem[word_index(DST_ADDR + 4 * k)] = exp_word;
		end
		verify_memory("after brightness job");	// src and guard as before
		// empty job finishes without memory traffic
		cpu_write(PIX_BASE + 8, 32'h0);
		cpu_write(CTRL_ADDR, {16'h0, ofs, 8'h01});
		wait_for_done();
		@(negedge clk);
		compare_word("pix_done len 0", {31'b0, pix_done}, 32'h1);
		verify_memory("after empty job");
	endtask

	initial begin
		void'($urandom(32'ha3a2_0396));	// one seed for the whole run
		errors    = 0;
		checks    = 0;
		last_lat  = 0;
		reset     = 1'b1;
		cpu_cs_n  = 1'b1;
		cpu_we    = 1'b0;
		cpu_addr  = '0;
		cpu_wdata = '0;
		repeat (4) @(posedge clk);
		reset <= 1'b0;
		reset_and_first_write();
		mem_round_trip();
		reg_readback();
		unmapped_access();
		brightness_job();
		repeat (4) @(posedge clk);
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

// File: list.f
hdl/sys_bus_pkg.sv
hdl/bus_ifs.sv
hdl/bus_arbiter.sv
hdl/bus_hub.sv
hdl/sram_slave.sv
hdl/pix_regs.sv
hdl/pix_dma.sv
hdl/soc_top.sv
sim/tb_soc.sv

// File: Makefile
# Verilator build and run of the system bus testbench
VERILATOR ?= verilator
TOP       ?= tb_soc
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= *** PASSED ***
VFLAGS    ?= --binary --timing --assert -Wno-fatal --timescale 1ns/1ps

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -qF -- "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
